// ==== Bender.yml ====
package:
  name: bird_shot_game

export_include_dirs:
  - include

sources:
  - files:
      - rtl/game_pkg.sv
      - rtl/rasterScan.sv
      - rtl/birdRenderer.sv
      - rtl/shotRenderer.sv
      - rtl/hitDetector.sv
      - rtl/birdShotGame.sv
  - target: test
    files:
      - tests/birdShotGame_chk.sv
      - tests/birdShotGame_tb.sv

// ==== include/game_defines.svh ====
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Raster size
// ~~~~~~~~~~~~~~~~~~~~

// Kept small for simulation, a full-size raster is 640 by 480
`define GAME_H_PIXELS 64
`define GAME_V_LINES 48

// Must hold the largest of the two raster dimensions
`define GAME_COORD_W 8

// ~~~~~~~~~~~~~~~~~~~~
// Object tables
// ~~~~~~~~~~~~~~~~~~~~

`define GAME_NUM_BIRDS 2
`define GAME_NUM_SHOTS 8

// Bird square side and shot bar length share this width
`define GAME_SIZE_W 4

`define GAME_SCORE_W 16

// One host word holds one table entry of either kind
`define GAME_OBJ_W 32

`endif

// ==== rtl/birdRenderer.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module birdRenderer (
	input logic clk,
	input logic resetN,
	input logic [`GAME_COORD_W-1:0] pixelX,
	input logic [`GAME_COORD_W-1:0] pixelY,
	input logic objWrite,
	input logic objIsShot,
	input logic [$clog2(`GAME_NUM_SHOTS)-1:0] objIndex,
	input game_pkg::objWord_t objData,
	output logic [`GAME_NUM_BIRDS-1:0] birdsDrawingRequest
);

	import game_pkg::*;

	localparam int SLOT_W = $clog2(`GAME_NUM_BIRDS);

	birdEntry_t birdTable [`GAME_NUM_BIRDS];
	logic [`GAME_COORD_W:0] birdRight [`GAME_NUM_BIRDS]; // One past the last column
	logic [`GAME_COORD_W:0] birdBottom [`GAME_NUM_BIRDS];
	logic [`GAME_NUM_BIRDS-1:0] insideBird;
	logic birdWrite;

	// Slots above the table size are dropped
	assign birdWrite = objWrite && !objIsShot && (objIndex < `GAME_NUM_BIRDS);

	// ~~~~~~~~~~~~~~~~~~~~
	// Host table
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < `GAME_NUM_BIRDS; i++)
				birdTable[i] <= '0;
		end else if (birdWrite) begin
			birdTable[objIndex[SLOT_W-1:0]] <= objData.bird;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Square test per bird
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int i = 0; i < `GAME_NUM_BIRDS; i++) begin
			birdRight[i] = birdTable[i].birdX + birdTable[i].birdSize;
			birdBottom[i] = birdTable[i].birdY + birdTable[i].birdSize;
			insideBird[i] = birdTable[i].alive
				&& (pixelX >= birdTable[i].birdX) && ({1'b0, pixelX} < birdRight[i])
				&& (pixelY >= birdTable[i].birdY) && ({1'b0, pixelY} < birdBottom[i]);
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			birdsDrawingRequest <= '0;
		else
			birdsDrawingRequest <= insideBird; // One cycle behind the coordinates
	end

endmodule

// ==== rtl/birdShotGame.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module birdShotGame (
	input logic clk,
	input logic resetN,
	input logic objWrite,
	input logic objIsShot,
	input logic [$clog2(`GAME_NUM_SHOTS)-1:0] objIndex,
	input game_pkg::objWord_t objData,
	output logic [`GAME_COORD_W-1:0] pixelX,
	output logic [`GAME_COORD_W-1:0] pixelY,
	output logic startOfFrame,
	output logic [`GAME_NUM_BIRDS-1:0] birdsDrawingRequest,
	output logic [`GAME_NUM_SHOTS-1:0] shotsDrawingRequest,
	output logic [`GAME_NUM_BIRDS-1:0] hitBirds,
	output logic [`GAME_NUM_SHOTS-1:0] hitShots,
	output logic [`GAME_SCORE_W-1:0] hitScore
);

	rasterScan scanner (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.startOfFrame(startOfFrame)
	);

	// Both renderers see the whole host port and pick their own writes
	birdRenderer birdDraw (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.objWrite(objWrite),
		.objIsShot(objIsShot),
		.objIndex(objIndex),
		.objData(objData),
		.birdsDrawingRequest(birdsDrawingRequest)
	);

	shotRenderer shotDraw (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.objWrite(objWrite),
		.objIsShot(objIsShot),
		.objIndex(objIndex),
		.objData(objData),
		.shotsDrawingRequest(shotsDrawingRequest)
	);

	hitDetector hitDetect (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.birdsDrawingRequest(birdsDrawingRequest),
		.shotsDrawingRequest(shotsDrawingRequest),
		.hitBirds(hitBirds),
		.hitShots(hitShots),
		.hitScore(hitScore)
	);

endmodule

// ==== rtl/game_pkg.sv ====
`include "game_defines.svh"

package game_pkg;

	// Unused high bits of an entry, so that both entry kinds fill one host word
	localparam int ENTRY_PAD_W = `GAME_OBJ_W - 1 - 2 * `GAME_COORD_W - `GAME_SIZE_W;

	// ~~~~~~~~~~~~~~~~~~~~
	// Table entries
	// ~~~~~~~~~~~~~~~~~~~~

	// Filled square, top-left corner at birdX, birdY
	typedef struct packed {
		logic alive;
		logic [ENTRY_PAD_W-1:0] padding;
		logic [`GAME_COORD_W-1:0] birdX;
		logic [`GAME_COORD_W-1:0] birdY;
		logic [`GAME_SIZE_W-1:0] birdSize;
	} birdEntry_t;

	// Vertical bar one pixel wide, growing downwards from shotY
	typedef struct packed {
		logic active;
		logic [ENTRY_PAD_W-1:0] padding;
		logic [`GAME_COORD_W-1:0] shotX;
		logic [`GAME_COORD_W-1:0] shotY;
		logic [`GAME_SIZE_W-1:0] shotLength;
	} shotEntry_t;

	// Host data word, read as a bird or as a shot depending on the target table
	typedef union packed {
		birdEntry_t bird;
		shotEntry_t shot;
	} objWord_t;

endpackage

// ==== rtl/hitDetector.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module hitDetector (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic [`GAME_NUM_BIRDS-1:0] birdsDrawingRequest,
	input logic [`GAME_NUM_SHOTS-1:0] shotsDrawingRequest,
	output logic [`GAME_NUM_BIRDS-1:0] hitBirds,
	output logic [`GAME_NUM_SHOTS-1:0] hitShots,
	output logic [`GAME_SCORE_W-1:0] hitScore
);

	localparam int COUNT_W = $clog2(`GAME_NUM_BIRDS + 1);

	logic anyBird;
	logic anyShot;
	logic [`GAME_NUM_BIRDS-1:0] newBirdHits;
	logic [`GAME_NUM_SHOTS-1:0] newShotHits;
	logic [COUNT_W-1:0] newBirdCount;
	logic [`GAME_SCORE_W:0] scoreSum; // Extra bit catches the overflow

	assign anyBird = |birdsDrawingRequest;
	assign anyShot = |shotsDrawingRequest;

	// ~~~~~~~~~~~~~~~~~~~~
	// Collisions
	// ~~~~~~~~~~~~~~~~~~~~

	// The hit bits double as the once-per-frame flags, and the frame start wins
	assign newBirdHits = birdsDrawingRequest & {`GAME_NUM_BIRDS{anyShot}} & ~hitBirds
		& {`GAME_NUM_BIRDS{!startOfFrame}};
	assign newShotHits = shotsDrawingRequest & {`GAME_NUM_SHOTS{anyBird}} & ~hitShots;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hitBirds <= '0;
			hitShots <= '0;
		end else if (startOfFrame) begin
			hitBirds <= '0; // Every object may be hit again in the new frame
			hitShots <= '0;
		end else begin
			hitBirds <= hitBirds | newBirdHits;
			hitShots <= hitShots | newShotHits;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Score
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		newBirdCount = '0;
		for (int i = 0; i < `GAME_NUM_BIRDS; i++)
			newBirdCount = newBirdCount + COUNT_W'(newBirdHits[i]);
	end

	assign scoreSum = {1'b0, hitScore} + (`GAME_SCORE_W + 1)'(newBirdCount);

	// Only reset clears the score, it does not restart with the frame
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			hitScore <= '0;
		else if (scoreSum[`GAME_SCORE_W])
			hitScore <= '1; // Saturate
		else
			hitScore <= scoreSum[`GAME_SCORE_W-1:0];
	end

endmodule

// ==== rtl/rasterScan.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module rasterScan (
	input logic clk,
	input logic resetN,
	output logic [`GAME_COORD_W-1:0] pixelX,
	output logic [`GAME_COORD_W-1:0] pixelY,
	output logic startOfFrame
);

	logic lastPixel;
	logic lastLine;

	assign lastPixel = (pixelX == `GAME_COORD_W'(`GAME_H_PIXELS - 1));
	assign lastLine = (pixelY == `GAME_COORD_W'(`GAME_V_LINES - 1));

	// ~~~~~~~~~~~~~~~~~~~~
	// Pixel and line counters
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pixelX <= '0;
			pixelY <= '0;
		end else begin
			if (lastPixel) begin
				pixelX <= '0;
				if (lastLine)
					pixelY <= '0; // Wrap to the top of the next frame
				else
					pixelY <= pixelY + 1'b1;
			end else begin
				pixelX <= pixelX + 1'b1;
			end
		end
	end

	// Decoded from the counters, so it is already high in the first cycle after reset
	assign startOfFrame = (pixelX == '0) && (pixelY == '0);

endmodule

// ==== rtl/shotRenderer.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module shotRenderer (
	input logic clk,
	input logic resetN,
	input logic [`GAME_COORD_W-1:0] pixelX,
	input logic [`GAME_COORD_W-1:0] pixelY,
	input logic objWrite,
	input logic objIsShot,
	input logic [$clog2(`GAME_NUM_SHOTS)-1:0] objIndex,
	input game_pkg::objWord_t objData,
	output logic [`GAME_NUM_SHOTS-1:0] shotsDrawingRequest
);

	import game_pkg::*;

	shotEntry_t shotTable [`GAME_NUM_SHOTS];
	logic [`GAME_COORD_W:0] shotEnd [`GAME_NUM_SHOTS]; // One below the last line of the bar
	logic [`GAME_NUM_SHOTS-1:0] onShot;
	logic shotWrite;

	// objIndex covers the whole shot table, so every slot is valid
	assign shotWrite = objWrite && objIsShot;

	// ~~~~~~~~~~~~~~~~~~~~
	// Host table
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < `GAME_NUM_SHOTS; i++)
				shotTable[i] <= '0;
		end else if (shotWrite) begin
			shotTable[objIndex] <= objData.shot;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Bar test per shot
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int i = 0; i < `GAME_NUM_SHOTS; i++) begin
			shotEnd[i] = shotTable[i].shotY + shotTable[i].shotLength;

			// A bar is a single column
			onShot[i] = shotTable[i].active
				&& (pixelX == shotTable[i].shotX)
				&& (pixelY >= shotTable[i].shotY)
				&& ({1'b0, pixelY} < shotEnd[i]);
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			shotsDrawingRequest <= '0;
		else
			shotsDrawingRequest <= onShot; // Lines up with the bird requests
	end

endmodule

// ==== tests/birdShotGame_chk.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module birdShotGame_chk (
	input logic clk,
	input logic resetN,
	input logic objWrite,
	input logic objIsShot,
	input logic [$clog2(`GAME_NUM_SHOTS)-1:0] objIndex,
	input game_pkg::objWord_t objData,
	input logic [`GAME_COORD_W-1:0] pixelX,
	input logic [`GAME_COORD_W-1:0] pixelY,
	input logic startOfFrame,
	input logic [`GAME_NUM_BIRDS-1:0] birdsDrawingRequest,
	input logic [`GAME_NUM_SHOTS-1:0] shotsDrawingRequest,
	input logic [`GAME_NUM_BIRDS-1:0] hitBirds,
	input logic [`GAME_NUM_SHOTS-1:0] hitShots,
	input logic [`GAME_SCORE_W-1:0] hitScore
);

	import game_pkg::*;

	localparam int HITS_W = `GAME_NUM_BIRDS + `GAME_NUM_SHOTS;

	int errorCount = 0;
	birdEntry_t birdModel [`GAME_NUM_BIRDS];
	shotEntry_t shotModel [`GAME_NUM_SHOTS];
	logic [`GAME_COORD_W-1:0] expX;
	logic [`GAME_COORD_W-1:0] expY;
	logic [`GAME_NUM_BIRDS-1:0] expBirds;
	logic [`GAME_NUM_SHOTS-1:0] expShots;
	logic [HITS_W-1:0] allHits; // Birds in the high bits
	logic [HITS_W-1:0] meetNow;
	logic [HITS_W-1:0] meetQ;
	logic [HITS_W-1:0] lastHits;
	logic [`GAME_SCORE_W-1:0] lastScore;

	function automatic logic inSquare(birdEntry_t b, int x, int y);
		return b.alive && x >= b.birdX && x < b.birdX + b.birdSize
			&& y >= b.birdY && y < b.birdY + b.birdSize;
	endfunction

	function automatic logic onBar(shotEntry_t s, int x, int y);
		return s.active && x == s.shotX && y >= s.shotY && y < s.shotY + s.shotLength;
	endfunction

	assign allHits = {hitBirds, hitShots};
	assign meetNow = {birdsDrawingRequest & {`GAME_NUM_BIRDS{|shotsDrawingRequest}},
		shotsDrawingRequest & {`GAME_NUM_SHOTS{|birdsDrawingRequest}}};

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference tables
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < `GAME_NUM_BIRDS; i++)
				birdModel[i] <= '0;
			for (int i = 0; i < `GAME_NUM_SHOTS; i++)
				shotModel[i] <= '0;
			expX <= '0;
			expY <= '0;
			expBirds <= '0;
			expShots <= '0;
			meetQ <= '0;
			lastHits <= '0;
			lastScore <= '0;
		end else begin
			if (expX == `GAME_H_PIXELS - 1) begin
				expX <= '0;
				expY <= (expY == `GAME_V_LINES - 1) ? '0 : expY + 1'b1;
			end else begin
				expX <= expX + 1'b1;
			end
			for (int i = 0; i < `GAME_NUM_BIRDS; i++)
				expBirds[i] <= inSquare(birdModel[i], pixelX, pixelY);
			for (int i = 0; i < `GAME_NUM_SHOTS; i++)
				expShots[i] <= onBar(shotModel[i], pixelX, pixelY);
			if (objWrite && objIsShot)
				shotModel[int'(objIndex)] <= objData.shot;
			else if (objWrite && objIndex < `GAME_NUM_BIRDS)
				birdModel[int'(objIndex)] <= objData.bird; // Higher bird slots do not exist
			meetQ <= startOfFrame ? '0 : meetNow; // Frame start wins over a late collision
			lastHits <= allHits;
			lastScore <= hitScore;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Assertions
	// ~~~~~~~~~~~~~~~~~~~~

	resetClear: assert property (@(posedge clk) $rose(resetN) |-> allHits == '0
		&& hitScore == '0 && birdsDrawingRequest == '0 && shotsDrawingRequest == '0)
		else begin
			errorCount++;
			$error("At %0t hit bits, score or requests were not zero after reset", $time);
		end

	scanPosition: assert property (@(posedge clk) disable iff (!resetN)
		pixelX == expX && pixelY == expY)
		else begin
			errorCount++;
			$error("Error at %0t: pixelX, pixelY is %0d, %0d, expected %0d, %0d", $time,
				$sampled(pixelX), $sampled(pixelY), $sampled(expX), $sampled(expY));
		end

	frameStrobe: assert property (@(posedge clk) disable iff (!resetN)
		startOfFrame == (expX == '0 && expY == '0))
		else begin
			errorCount++;
			$error("Error at %0t: startOfFrame is %b, expected %b", $time,
				$sampled(startOfFrame), $sampled(expX == '0 && expY == '0));
		end

	drawBirds: assert property (@(posedge clk) disable iff (!resetN)
		birdsDrawingRequest == expBirds)
		else begin
			errorCount++;
			$error("Error at %0t: birdsDrawingRequest is %b, expected %b", $time,
				$sampled(birdsDrawingRequest), $sampled(expBirds));
		end

	drawShots: assert property (@(posedge clk) disable iff (!resetN)
		shotsDrawingRequest == expShots)
		else begin
			errorCount++;
			$error("Error at %0t: shotsDrawingRequest is %b, expected %b", $time,
				$sampled(shotsDrawingRequest), $sampled(expShots));
		end

	// Every collision of the previous cycle must show in the hit bits
	hitSet: assert property (@(posedge clk) disable iff (!resetN) (allHits & meetQ) == meetQ)
		else begin
			errorCount++;
			$error("Error at %0t: {hitBirds, hitShots} is %b, expected at least %b", $time,
				$sampled(allHits), $sampled(meetQ));
		end

	hitCause: assert property (@(posedge clk) disable iff (!resetN)
		(allHits & ~lastHits & ~meetQ) == '0)
		else begin
			errorCount++;
			$error("At %0t a hit bit rose without a collision in the cycle before", $time);
		end

	frameClear: assert property (@(posedge clk) disable iff (!resetN)
		startOfFrame |=> allHits == '0)
		else begin
			errorCount++;
			$error("At %0t hit bits were still set in the cycle after the frame start", $time);
		end

	scoreStep: assert property (@(posedge clk) disable iff (!resetN)
		hitScore == lastScore + $countones(hitBirds & ~lastHits[HITS_W-1:`GAME_NUM_SHOTS]))
		else begin
			errorCount++;
			$error("Error at %0t: hitScore is %0d, expected %0d", $time, $sampled(hitScore),
				$sampled(lastScore) + $countones($sampled(hitBirds)
				& ~$sampled(lastHits[HITS_W-1:`GAME_NUM_SHOTS])));
		end

endmodule

bind birdShotGame birdShotGame_chk checks (.*);

// ==== tests/birdShotGame_tb.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module birdShotGame_tb;

	import game_pkg::*;

	localparam int INDEX_W = $clog2(`GAME_NUM_SHOTS);
	localparam int FRAME_CYCLES = `GAME_H_PIXELS * `GAME_V_LINES;
	localparam int CYCLE_LIMIT = 8 * FRAME_CYCLES + 100; // Reset and host writes fit the slack

	logic clk = 1'b0;
	logic resetN;
	logic objWrite;
	logic objIsShot;
	logic [INDEX_W-1:0] objIndex;
	objWord_t objData;
	logic [`GAME_COORD_W-1:0] pixelX;
	logic [`GAME_COORD_W-1:0] pixelY;
	logic startOfFrame;
	logic [`GAME_NUM_BIRDS-1:0] birdsDrawingRequest;
	logic [`GAME_NUM_SHOTS-1:0] shotsDrawingRequest;
	logic [`GAME_NUM_BIRDS-1:0] hitBirds;
	logic [`GAME_NUM_SHOTS-1:0] hitShots;
	logic [`GAME_SCORE_W-1:0] hitScore;
	int cycleCount = 0;

	birdShotGame u_dut (.*);

	always #5 clk = ~clk;

	function automatic objWord_t birdWord(logic alive, int x, int y, int size);
		objWord_t w;
		w = '0;
		w.bird.alive = alive;
		w.bird.birdX = `GAME_COORD_W'(x);
		w.bird.birdY = `GAME_COORD_W'(y);
		w.bird.birdSize = `GAME_SIZE_W'(size);
		return w;
	endfunction

	function automatic objWord_t shotWord(logic active, int x, int y, int length);
		objWord_t w;
		w = '0;
		w.shot.active = active;
		w.shot.shotX = `GAME_COORD_W'(x);
		w.shot.shotY = `GAME_COORD_W'(y);
		w.shot.shotLength = `GAME_SIZE_W'(length);
		return w;
	endfunction

	// Called on a falling edge, leaves the port idle one cycle later
	task automatic writeEntry(input logic isShot, input int index, input objWord_t word);
		objWrite = 1'b1;
		objIsShot = isShot;
		objIndex = INDEX_W'(index);
		objData = word;
		@(negedge clk);
		objWrite = 1'b0;
	endtask

	task automatic waitFrameStart();
		do
			@(negedge clk);
		while (!startOfFrame);
	endtask

	task automatic loadRandomScene();
		for (int i = 0; i < `GAME_NUM_BIRDS; i++)
			writeEntry(1'b0, i, birdWord(1'b1, $urandom_range(0, 55), $urandom_range(2, 38),
				$urandom_range(1, 15)));
		for (int i = 0; i < `GAME_NUM_SHOTS; i++)
			writeEntry(1'b1, i, shotWord($urandom_range(0, 3) != 0, $urandom_range(0, 63),
				$urandom_range(2, 45), $urandom_range(1, 15)));
	endtask

	task automatic finishRun(input logic timedOut);
		$display("Run finished with %0d assertion failures and %0d timeouts",
			u_dut.checks.errorCount, timedOut);
		if (timedOut || u_dut.checks.errorCount != 0)
			$display("SOME TESTS FAILED");
		else
			$display("ALL TESTS PASSED");
		$finish;
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the frames did not complete", cycleCount);
			finishRun(1'b1);
		end
	end

	initial begin
		void'($urandom(32'h6616));
		resetN = 1'b0;
		objWrite = 1'b0;
		objIsShot = 1'b0;
		objIndex = '0;
		objData = '0;
		repeat (8) @(negedge clk);
		resetN = 1'b1;

		// Bird 0 is crossed by two shots, bird 1 stays clear
		waitFrameStart();
		writeEntry(1'b0, 0, birdWord(1'b1, 10, 10, 8));
		writeEntry(1'b0, 1, birdWord(1'b1, 30, 30, 4));
		writeEntry(1'b1, 0, shotWord(1'b1, 12, 8, 6));
		writeEntry(1'b1, 1, shotWord(1'b1, 15, 14, 10));
		for (int i = 2; i < `GAME_NUM_SHOTS; i++)
			writeEntry(1'b1, i, shotWord(1'b1, 38 + i, 30, 4));

		// Everything apart
		waitFrameStart();
		writeEntry(1'b0, 0, birdWord(1'b1, 5, 5, 6));
		writeEntry(1'b0, 1, birdWord(1'b1, 20, 5, 6));
		writeEntry(1'b0, 5, birdWord(1'b1, 36, 20, 8)); // No such bird slot, must be dropped
		for (int i = 0; i < `GAME_NUM_SHOTS; i++)
			writeEntry(1'b1, i, shotWord(1'b1, 36 + 2 * i, 20, 8));

		// Both birds hit, the idle shots lie on bird 0 but are inactive
		waitFrameStart();
		writeEntry(1'b0, 0, birdWord(1'b1, 10, 20, 10));
		writeEntry(1'b0, 1, birdWord(1'b1, 40, 20, 10));
		writeEntry(1'b1, 0, shotWord(1'b1, 12, 15, 10));
		writeEntry(1'b1, 1, shotWord(1'b1, 45, 25, 3));
		for (int i = 2; i < `GAME_NUM_SHOTS; i++)
			writeEntry(1'b1, i, shotWord(1'b0, 14, 22, 5));

		for (int f = 0; f < 3; f++) begin
			waitFrameStart();
			loadRandomScene();
		end
		waitFrameStart();
		finishRun(1'b0);
	end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/game_pkg.sv
rtl/rasterScan.sv
rtl/birdRenderer.sv
rtl/shotRenderer.sv
rtl/hitDetector.sv
rtl/birdShotGame.sv
tests/birdShotGame_chk.sv
tests/birdShotGame_tb.sv
